// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pic_control_logic
FILELIST  = pic_control_logic.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== pic_control_logic.f ====
src/pic_pkg.sv
src/pic_command_regs.sv
src/pic_ack_control.sv
src/pic_eoi_decode.sv
src/pic_vector_mux.sv
src/pic_control_logic.sv
testbench/pic_control_logic_sva.sv
testbench/tb_pic_control_logic.sv

// ==== src/pic_ack_control.sv ====
`timescale 1ns/1ps

module pic_ack_control
	import pic_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        inta_n,
	input  logic        read,
	input  logic        poll_cmd,
	input  irq_vec_t    interrupt,
	output ctrl_state_e ctrl_state,
	output logic        latch_in_service,
	output logic        end_of_ack,
	output logic        end_of_poll,
	output logic        freeze,
	output logic        interrupt_to_cpu
);

	ctrl_state_e next_state;
	logic        inta_n_q;
	logic        read_q;
	logic        inta_fall;
	logic        inta_rise;
	logic        read_fall;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			inta_n_q <= 1'b1;
			read_q <= 1'b0;
		end
		else
		begin
			inta_n_q <= inta_n;
			read_q <= read;
		end
	end

	assign inta_fall = inta_n_q & ~inta_n;
	assign inta_rise = ~inta_n_q & inta_n;
	assign read_fall = read_q & ~read;

	// Poll takes precedence over a new acknowledge
	always_comb
	begin
		next_state = ctrl_state;
		case (ctrl_state)
			ctrl_idle:
				if (poll_cmd)
					next_state = ctrl_poll;
				else if (inta_fall)
					next_state = ctrl_ack1;
			ctrl_ack1:
				if (inta_rise)
					next_state = ctrl_ack2;
			ctrl_ack2:
				if (inta_rise)
					next_state = ctrl_idle;
			ctrl_poll:
				if (read_fall)
					next_state = ctrl_idle;
			default:
				next_state = ctrl_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ctrl_state <= ctrl_idle;
		else
			ctrl_state <= next_state;
	end

	assign latch_in_service = (ctrl_state == ctrl_idle) && (next_state != ctrl_idle);
	assign end_of_ack = (ctrl_state == ctrl_ack2) && (next_state == ctrl_idle);
	assign end_of_poll = (ctrl_state == ctrl_poll) && (next_state == ctrl_idle);
	assign freeze = (ctrl_state != ctrl_idle);

	// A pending request keeps INT asserted
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			interrupt_to_cpu <= 1'b0;
		else if (interrupt != '0)
			interrupt_to_cpu <= 1'b1;
		else if (end_of_ack || end_of_poll)
			interrupt_to_cpu <= 1'b0;
	end

endmodule

// ==== src/pic_command_regs.sv ====
`timescale 1ns/1ps

module pic_command_regs
	import pic_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  cmd_strobe_t strobes,
	input  data_byte_t  data_bus,
	output pic_config_t cfg,
	output irq_vec_t    interrupt_mask,
	output logic        ocw2_write,
	output logic        poll_cmd,
	output logic        icw1_seen
);

	init_state_e init_state;
	logic        icw4_needed;
	logic        ready;

	assign ready = (init_state == init_ready);

	// ICW1 restarts the sequence from any state
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			init_state <= init_ready;
			icw4_needed <= 1'b0;
		end
		else if (strobes.icw_1)
		begin
			init_state <= init_icw2;
			icw4_needed <= data_bus[0];
		end
		else if (strobes.icw_2_4)
		begin
			case (init_state)
				init_icw2: init_state <= icw4_needed ? init_icw4 : init_ready;
				init_icw4: init_state <= init_ready;
				default: init_state <= init_state;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cfg <= '0;
		else if (strobes.icw_1)
		begin
			cfg.level_triggered <= data_bus[3];
			cfg.auto_eoi <= 1'b0;
		end
		else if (strobes.icw_2_4 && (init_state == init_icw2))
			cfg.vector_base <= data_bus[7:3];
		else if (strobes.icw_2_4 && (init_state == init_icw4))
			cfg.auto_eoi <= data_bus[1];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			interrupt_mask <= '0;
		else if (strobes.icw_1)
			interrupt_mask <= '0;
		else if (strobes.ocw_1 && ready)
			interrupt_mask <= data_bus;
	end

	// OCW2/OCW3 only count once initialization is done
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ocw2_write <= 1'b0;
			poll_cmd <= 1'b0;
			icw1_seen <= 1'b0;
		end
		else
		begin
			ocw2_write <= strobes.ocw_2 && ready;
			poll_cmd <= strobes.ocw_3 && ready && data_bus[ocw3_poll_bit];
			icw1_seen <= strobes.icw_1;
		end
	end

endmodule

// ==== src/pic_control_logic.sv ====
`timescale 1ns/1ps

module pic_control_logic
	import pic_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  cmd_strobe_t strobes,
	input  data_byte_t  data_bus,
	input  logic        inta_n,
	input  logic        read,
	input  irq_vec_t    interrupt,
	input  irq_vec_t    highest_level_in_service,
	output logic        interrupt_to_cpu,
	output logic        freeze,
	output logic        latch_in_service,
	output logic        level_triggered,
	output logic        data_enable,
	output data_byte_t  data_out,
	output irq_vec_t    interrupt_mask,
	output irq_vec_t    end_of_interrupt,
	output irq_vec_t    clear_interrupt_request
);

	pic_config_t cfg;
	ctrl_state_e ctrl_state;
	irq_vec_t    acknowledged;
	logic        ocw2_write;
	logic        poll_cmd;
	logic        icw1_seen;
	logic        end_of_ack;
	logic        end_of_poll;

	assign level_triggered = cfg.level_triggered;

	pic_command_regs i_pic_command_regs (
		.clk            (clk),
		.arst_n         (arst_n),
		.strobes        (strobes),
		.data_bus       (data_bus),
		.cfg            (cfg),
		.interrupt_mask (interrupt_mask),
		.ocw2_write     (ocw2_write),
		.poll_cmd       (poll_cmd),
		.icw1_seen      (icw1_seen)
	);

	pic_ack_control i_pic_ack_control (
		.clk              (clk),
		.arst_n           (arst_n),
		.inta_n           (inta_n),
		.read             (read),
		.poll_cmd         (poll_cmd),
		.interrupt        (interrupt),
		.ctrl_state       (ctrl_state),
		.latch_in_service (latch_in_service),
		.end_of_ack       (end_of_ack),
		.end_of_poll      (end_of_poll),
		.freeze           (freeze),
		.interrupt_to_cpu (interrupt_to_cpu)
	);

	pic_eoi_decode i_pic_eoi_decode (
		.clk                      (clk),
		.arst_n                   (arst_n),
		.ocw2_write               (ocw2_write),
		.data_bus                 (data_bus),
		.highest_level_in_service (highest_level_in_service),
		.auto_eoi                 (cfg.auto_eoi),
		.end_of_ack               (end_of_ack),
		.acknowledged             (acknowledged),
		.end_of_interrupt         (end_of_interrupt)
	);

	pic_vector_mux i_pic_vector_mux (
		.clk                     (clk),
		.arst_n                  (arst_n),
		.ctrl_state              (ctrl_state),
		.inta_n                  (inta_n),
		.read                    (read),
		.latch_in_service        (latch_in_service),
		.end_of_ack              (end_of_ack),
		.end_of_poll             (end_of_poll),
		.icw1_seen               (icw1_seen),
		.interrupt               (interrupt),
		.vector_base             (cfg.vector_base),
		.acknowledged            (acknowledged),
		.clear_interrupt_request (clear_interrupt_request),
		.data_out                (data_out),
		.data_enable             (data_enable)
	);

endmodule

// ==== src/pic_eoi_decode.sv ====
`timescale 1ns/1ps

module pic_eoi_decode
	import pic_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ocw2_write,
	input  data_byte_t data_bus,
	input  irq_vec_t   highest_level_in_service,
	input  logic       auto_eoi,
	input  logic       end_of_ack,
	input  irq_vec_t   acknowledged,
	output irq_vec_t   end_of_interrupt
);

	data_byte_t ocw2_byte;
	irq_vec_t   eoi_next;

	// Lines up with the registered OCW2 pulse
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ocw2_byte <= '0;
		else
			ocw2_byte <= data_bus;
	end

	always_comb
	begin
		eoi_next = '0;
		if (auto_eoi && end_of_ack)
			eoi_next = acknowledged;
		else if (ocw2_write)
		begin
			case (ocw2_byte[6:5])
				ocw2_eoi_nonspecific: eoi_next = highest_level_in_service;
				ocw2_eoi_specific: eoi_next = irq_vec_t'(1) << ocw2_byte[2:0];
				default: eoi_next = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			end_of_interrupt <= '0;
		else
			end_of_interrupt <= eoi_next;
	end

endmodule

// ==== src/pic_pkg.sv ====
package pic_pkg;

	localparam int num_levels = 8;

	// OCW2 bits 6:5
	localparam logic [1:0] ocw2_eoi_nonspecific = 2'b01;
	localparam logic [1:0] ocw2_eoi_specific = 2'b11;

	localparam int ocw3_poll_bit = 2;
	localparam logic [4:0] poll_flag_byte_top = 5'b10000;

	typedef logic [7:0] data_byte_t;
	typedef logic [num_levels-1:0] irq_vec_t;
	typedef logic [2:0] irq_level_t;
	typedef logic [4:0] vector_base_t;

	typedef enum logic [1:0] {
		init_ready,
		init_icw2,
		init_icw4
	} init_state_e;

	typedef enum logic [1:0] {
		ctrl_idle,
		ctrl_ack1,
		ctrl_ack2,
		ctrl_poll
	} ctrl_state_e;

	typedef struct packed {
		logic icw_1;
		logic icw_2_4;
		logic ocw_1;
		logic ocw_2;
		logic ocw_3;
	} cmd_strobe_t;

	typedef struct packed {
		logic         level_triggered;
		logic         auto_eoi;
		vector_base_t vector_base;
	} pic_config_t;

	// Level 0 has the highest priority
	function automatic irq_level_t lowest_level(input irq_vec_t vec);
		irq_level_t level;
		level = '0;
		for (int i = num_levels - 1; i >= 0; i--)
		begin
			if (vec[i])
				level = irq_level_t'(i);
		end
		return level;
	endfunction

endpackage

// ==== src/pic_vector_mux.sv ====
`timescale 1ns/1ps

module pic_vector_mux
	import pic_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  ctrl_state_e  ctrl_state,
	input  logic         inta_n,
	input  logic         read,
	input  logic         latch_in_service,
	input  logic         end_of_ack,
	input  logic         end_of_poll,
	input  logic         icw1_seen,
	input  irq_vec_t     interrupt,
	input  vector_base_t vector_base,
	output irq_vec_t     acknowledged,
	output irq_vec_t     clear_interrupt_request,
	output data_byte_t   data_out,
	output logic         data_enable
);

	irq_vec_t   clear_q;
	irq_level_t ack_level;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			acknowledged <= '0;
		else if (end_of_ack || end_of_poll)
			acknowledged <= '0;
		else if (latch_in_service)
			acknowledged <= interrupt;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			clear_q <= '0;
		else if (latch_in_service)
			clear_q <= interrupt;
		else
			clear_q <= '0;
	end

	// Initialization wipes every pending request
	assign clear_interrupt_request = icw1_seen ? '1 : clear_q;

	assign ack_level = lowest_level(acknowledged);

	always_comb
	begin
		data_enable = 1'b0;
		data_out = '0;
		if ((ctrl_state == ctrl_ack2) && !inta_n)
		begin
			data_enable = 1'b1;
			data_out = {vector_base, ack_level};
		end
		else if ((ctrl_state == ctrl_poll) && read)
		begin
			data_enable = 1'b1;
			if (acknowledged != '0)
				data_out = {poll_flag_byte_top, ack_level};
		end
	end

endmodule

// ==== testbench/pic_control_logic_sva.sv ====
`timescale 1ns/1ps

module pic_control_logic_sva
	import pic_pkg::*;
(
	input logic        clk,
	input logic        arst_n,
	input cmd_strobe_t strobes,
	input data_byte_t  data_bus,
	input logic        read,
	input irq_vec_t    interrupt,
	input logic        interrupt_to_cpu,
	input logic        freeze,
	input logic        latch_in_service,
	input logic        level_triggered,
	input logic        data_enable,
	input irq_vec_t    clear_interrupt_request
);

	// ICW1 wipes all requests and takes the trigger mode
	icw1_clear: assert property (@(posedge clk) disable iff (!arst_n)
		strobes.icw_1 |=> (clear_interrupt_request == '1)
			&& (level_triggered == $past(data_bus[3])))
	else
	begin
		$error("** Error @ %0t: ICW1 did not clear requests or set trigger mode", $time);
		tb_pic_control_logic.error_count++;
	end

	int_request_set: assert property (@(posedge clk) disable iff (!arst_n)
		(interrupt != '0) |=> interrupt_to_cpu)
	else
	begin
		$error("** Error @ %0t: interrupt_to_cpu did not rise", $time);
		tb_pic_control_logic.error_count++;
	end

	// Latch only on leaving idle, so once per sequence
	latch_once: assert property (@(posedge clk) disable iff (!arst_n)
		latch_in_service |-> !freeze ##1 (freeze
			&& (clear_interrupt_request == $past(interrupt))))
	else
	begin
		$error("** Error @ %0t: latch_in_service or request clear wrong", $time);
		tb_pic_control_logic.error_count++;
	end

	data_only_frozen: assert property (@(posedge clk) disable iff (!arst_n)
		data_enable |-> freeze)
	else
	begin
		$error("** Error @ %0t: data_enable outside a sequence", $time);
		tb_pic_control_logic.error_count++;
	end

	poll_end: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(read) |-> !data_enable ##1 !freeze)
	else
	begin
		$error("** Error @ %0t: poll did not end after read fell", $time);
		tb_pic_control_logic.error_count++;
	end

endmodule

// ==== testbench/tb_pic_control_logic.sv ====
`timescale 1ns/1ps

module tb_pic_control_logic
	import pic_pkg::*;
;

	localparam int max_cycles = 2000;
	localparam cmd_strobe_t s_icw1 = 5'b10000;
	localparam cmd_strobe_t s_icw24 = 5'b01000;
	localparam cmd_strobe_t s_ocw1 = 5'b00100;
	localparam cmd_strobe_t s_ocw2 = 5'b00010;
	localparam cmd_strobe_t s_ocw3 = 5'b00001;

	logic clk;
	logic arst_n;
	cmd_strobe_t strobes;
	data_byte_t data_bus;
	logic inta_n;
	logic read;
	irq_vec_t interrupt;
	irq_vec_t highest_level_in_service;
	logic interrupt_to_cpu;
	logic freeze;
	logic latch_in_service;
	logic level_triggered;
	logic data_enable;
	data_byte_t data_out;
	irq_vec_t interrupt_mask;
	irq_vec_t end_of_interrupt;
	irq_vec_t clear_interrupt_request;

	int error_count = 0;
	int cycle_count = 0;
	integer seed = 73963;

	// Reference model of the configuration
	int init_stage = 0;
	logic need_icw4 = 1'b0;
	logic auto_cfg = 1'b0;
	vector_base_t expect_base = '0;
	irq_vec_t expect_eoi = '0;
	irq_vec_t expect_irq = '0;
	irq_level_t expect_level = '0;
	data_byte_t expect_poll = '0;
	int ack_phase = 0;
	logic poll_active = 1'b0;

	pic_control_logic i_pic_control_logic (.*);

	bind pic_control_logic pic_control_logic_sva i_pic_control_logic_sva (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	mask_locked: assert property (@(posedge clk) disable iff (!arst_n)
		(strobes.ocw_1 && init_stage != 0) |=> interrupt_mask == '0)
	else
	begin
		$display("** Error @ %0t: mask written during initialization", $time);
		error_count++;
	end

	mask_load: assert property (@(posedge clk) disable iff (!arst_n)
		(strobes.ocw_1 && init_stage == 0) |=> interrupt_mask == $past(data_bus))
	else
	begin
		$display("** Error @ %0t: interrupt_mask %h wrong", $time, interrupt_mask);
		error_count++;
	end

	first_pulse_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		(!inta_n && ack_phase == 1) |-> !data_enable)
	else
	begin
		$display("** Error @ %0t: data driven during first INTA", $time);
		error_count++;
	end

	vector_out: assert property (@(posedge clk) disable iff (!arst_n)
		(!inta_n && ack_phase == 2) |-> data_enable
			&& (data_out == {expect_base, expect_level}))
	else
	begin
		$display("** Error @ %0t: vector %h, expected %h", $time, data_out,
			{expect_base, expect_level});
		error_count++;
	end

	freeze_span: assert property (@(posedge clk) disable iff (!arst_n)
		($fell(inta_n) && ack_phase == 1) |=> freeze [*6] ##1 !freeze)
	else
	begin
		$display("** Error @ %0t: freeze does not span the acknowledge", $time);
		error_count++;
	end

	int_cleared: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(inta_n) && ack_phase == 2 && interrupt == '0) |=> !interrupt_to_cpu)
	else
	begin
		$display("** Error @ %0t: interrupt_to_cpu still high", $time);
		error_count++;
	end

	auto_eoi_out: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(inta_n) && ack_phase == 2)
			|=> end_of_interrupt == (auto_cfg ? expect_irq : irq_vec_t'(0)))
	else
	begin
		$display("** Error @ %0t: end_of_interrupt %h at end of ack", $time,
			end_of_interrupt);
		error_count++;
	end

	ocw2_eoi: assert property (@(posedge clk) disable iff (!arst_n)
		(strobes.ocw_2 && init_stage == 0)
			|-> ##2 (end_of_interrupt == expect_eoi) ##1 (end_of_interrupt == '0))
	else
	begin
		$display("** Error @ %0t: end_of_interrupt %h, expected %h", $time,
			end_of_interrupt, expect_eoi);
		error_count++;
	end

	poll_out: assert property (@(posedge clk) disable iff (!arst_n)
		(read && poll_active) |-> data_enable && (data_out == expect_poll))
	else
	begin
		$display("** Error @ %0t: poll byte %h, expected %h", $time, data_out,
			expect_poll);
		error_count++;
	end

	task automatic write_command(input cmd_strobe_t s, input data_byte_t d);
		@(posedge clk);
		strobes <= s;
		data_bus <= d;
		if (s.icw_1)
		begin
			init_stage <= 1;
			need_icw4 <= d[0];
			auto_cfg <= 1'b0;
		end
		else if (s.icw_2_4 && init_stage == 1)
		begin
			expect_base <= d[7:3];
			init_stage <= need_icw4 ? 2 : 0;
		end
		else if (s.icw_2_4 && init_stage == 2)
		begin
			auto_cfg <= d[1];
			init_stage <= 0;
		end
		else if (s.ocw_2)
		begin
			if (d[6:5] == 2'b01)
				expect_eoi <= highest_level_in_service;
			else if (d[6:5] == 2'b11)
				expect_eoi <= irq_vec_t'(1) << d[2:0];
			else
				expect_eoi <= '0;
		end
		@(posedge clk);
		strobes <= '0;
		repeat (3) @(posedge clk);
	endtask

	task automatic raise_request();
		irq_level_t lvl;
		lvl = irq_level_t'({$random(seed)} % 8);
		@(posedge clk);
		interrupt <= irq_vec_t'(1) << lvl;
		expect_irq <= irq_vec_t'(1) << lvl;
		expect_level <= lvl;
		repeat (2) @(posedge clk);
	endtask

	task automatic inta_pulse();
		@(posedge clk);
		ack_phase <= 1;
		inta_n <= 1'b0;
		repeat (2) @(posedge clk);
		inta_n <= 1'b1;
		repeat (2) @(posedge clk);
		ack_phase <= 2;
		inta_n <= 1'b0;
		// Request goes away once it is in service
		interrupt <= '0;
		repeat (2) @(posedge clk);
		inta_n <= 1'b1;
		repeat (2) @(posedge clk);
		ack_phase <= 0;
		repeat (2) @(posedge clk);
	endtask

	task automatic poll_read();
		@(posedge clk);
		poll_active <= 1'b1;
		expect_poll <= (interrupt != '0) ? {5'b10000, expect_level} : 8'h00;
		write_command(s_ocw3, 8'h0c);
		@(posedge clk);
		read <= 1'b1;
		repeat (2) @(posedge clk);
		read <= 1'b0;
		repeat (2) @(posedge clk);
		poll_active <= 1'b0;
		interrupt <= '0;
		repeat (2) @(posedge clk);
	endtask

	initial
	begin
		arst_n = 1'b0;
		strobes = '0;
		data_bus = '0;
		inta_n = 1'b1;
		read = 1'b0;
		interrupt = '0;
		highest_level_in_service = '0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		write_command(s_icw1, 8'h1b);
		write_command(s_ocw1, 8'ha5);
		write_command(s_icw24, 8'h40);
		write_command(s_icw24, 8'h01);
		write_command(s_ocw1, 8'h5a);

		highest_level_in_service <= 8'h04;
		repeat (4)
		begin
			raise_request();
			inta_pulse();
		end

		write_command(s_ocw2, 8'h20);
		write_command(s_ocw2, 8'h63);

		raise_request();
		poll_read();
		poll_read();

		// Second setup with auto EOI
		write_command(s_icw1, 8'h13);
		write_command(s_icw24, 8'h88);
		write_command(s_icw24, 8'h03);
		repeat (3)
		begin
			raise_request();
			inta_pulse();
		end

		repeat (5) @(posedge clk);
		$display("Run complete with %0d errors", error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		while (cycle_count < max_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("The run timed out after %0d cycles", cycle_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
